// ==== fpuAddRun.sh ====
#!/bin/sh
# Builds the FPU add testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=fpuAddSim.log

verilator --binary --timing -Wno-fatal --top-module fpuAddTb -Mdir "$buildDir" -f fpuAdd.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$buildDir/VfpuAddTb" > "$logFile" 2>&1
status=$?
cat "$logFile"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^TESTS PASSED$" "$logFile"; then
	exit 0
fi
echo "Pass message not found in $logFile"
exit 1

// ==== fpuAdd.f ====
fpuAddPkg.sv
fpuAddDecode.sv
fpuAddExecute.sv
fpuAddResult.sv
fpuAddUnit.sv
fpuAddChecker.sv
fpuAddTb.sv

// ==== fpuAddTb.sv ====
// FPU add unit testbench
// drives four-phase requests for add, subtract, I2F and opNone, computes
// the expected result with a bit-exact reference model, and bounds the run
`timescale 1ns/100ps
`default_nettype none

module fpuAddTb
	import fpuAddPkg::*;
();

	localparam int clockPeriod = 40;
	localparam int resetCycles = 5;
	localparam int expLimit = 2000;
	localparam int randomAddSubTests = 60;
	localparam int cancelTests = 4;
	localparam int alignTests = 4 + maxAlignShift;
	localparam int randomConvertTests = 20;
	localparam int convertTests = 4 + randomConvertTests;
	localparam int zeroTests = 3;
	localparam int backToBackTests = 20;
	localparam int numTests = 1 + randomAddSubTests + cancelTests + alignTests + convertTests
		+ zeroTests + backToBackTests;
	localparam int cyclesPerTest = 20;

	logic clock = 1'b0;
	logic rstN;
	logic req;
	fpuOp op;
	logic [63:0] rn;
	logic [63:0] rm;
	logic ack;
	logic [63:0] result;
	logic [63:0] expected;

	int errorCount;
	int reqCount;
	int ackCount;
	int tbErrors;
	int totalErrors;
	logic [63:0] rngState;

	always #(clockPeriod / 2) clock = ~clock;

	fpuAddUnit dut0
	(
		.clock  (clock),
		.rstN   (rstN),
		.req    (req),
		.op     (op),
		.rn     (rn),
		.rm     (rm),
		.ack    (ack),
		.result (result)
	);

	fpuAddChecker checker0
	(
		.clock      (clock),
		.rstN       (rstN),
		.req        (req),
		.op         (op),
		.rn         (rn),
		.rm         (rm),
		.expected   (expected),
		.ack        (ack),
		.result     (result),
		.errorCount (errorCount),
		.reqCount   (reqCount),
		.ackCount   (ackCount)
	);

	// unpack, order, align, add, normalize, truncate, flush underflow
	function automatic logic [63:0] fpuAddModel(input fpuOp mOp, input logic [63:0] a,
		input logic [63:0] b);
		logic signA;
		logic signB;
		logic outSign;
		int expA;
		int expB;
		int outExp;
		int shift;
		int lead;
		logic [63:0] mantA;
		logic [63:0] mantB;
		logic [63:0] bigM;
		logic [63:0] smallM;
		logic [63:0] sum;
		logic [63:0] norm;
		if (mOp == opNone)
		begin
			return 64'd0;
		end
		if (mOp == opI2F)
		begin
			// integer bit 62 carries weight 2^62
			outSign = a[63];
			sum = a[63] ? (~a + 64'd1) : a;
			outExp = i2fExponent;
		end
		else
		begin
			signA = a[63];
			signB = b[63] ^ (mOp == opSub);
			expA = int'(a[fracWidth +: expWidth]);
			expB = int'(b[fracWidth +: expWidth]);
			mantA = {1'b0, expA != 0, a[fracWidth-1:0], {guardBits{1'b0}}};
			mantB = {1'b0, expB != 0, b[fracWidth-1:0], {guardBits{1'b0}}};
			if ((expA > expB) || ((expA == expB) && (mantA >= mantB)))
			begin
				outSign = signA;
				outExp = expA;
				bigM = mantA;
				smallM = mantB;
				shift = expA - expB;
			end
			else
			begin
				outSign = signB;
				outExp = expB;
				bigM = mantB;
				smallM = mantA;
				shift = expB - expA;
			end
			smallM = (shift > maxAlignShift) ? 64'd0 : (smallM >> shift);
			sum = (signA == signB) ? (bigM + smallM) : (bigM - smallM);
		end
		if (sum == 64'd0)
		begin
			return 64'd0;
		end
		lead = 63;
		while (!sum[lead])
		begin
			lead--;
		end
		// hidden bit belongs at bit 62
		outExp = outExp + lead - 62;
		if (outExp < 0)
		begin
			return 64'd0;
		end
		norm = (lead == 63) ? (sum >> 1) : (sum << (62 - lead));
		return {outSign, 11'(outExp), norm[guardBits +: fracWidth]};
	endfunction

	function automatic logic [63:0] xorshift(input logic [63:0] value);
		logic [63:0] x;
		x = value;
		x = x ^ (x << 13);
		x = x ^ (x >> 7);
		x = x ^ (x << 17);
		return x;
	endfunction

	task automatic nextRandom(output logic [63:0] value);
		rngState = xorshift(rngState);
		value = rngState;
	endtask

	task automatic randomExponent(output int exponent);
		logic [63:0] r;
		nextRandom(r);
		exponent = int'(r[31:0] % 32'(expLimit));
	endtask

	task automatic randomOperand(input int exponent, output logic [63:0] value);
		logic [63:0] r;
		nextRandom(r);
		value = {r[63], 11'(exponent), r[fracWidth-1:0]};
	endtask

	// one full four-phase handshake, called on a falling edge
	task automatic runRequest(input fpuOp reqOp, input logic [63:0] a, input logic [63:0] b,
		input int holdCycles);
		op = reqOp;
		rn = a;
		rm = b;
		expected = fpuAddModel(reqOp, a, b);
		req = 1'b1;
		@(negedge clock);
		while (!ack)
		begin
			@(negedge clock);
		end
		repeat (holdCycles) @(negedge clock);
		req = 1'b0;
		@(negedge clock);
		while (ack)
		begin
			@(negedge clock);
		end
	endtask

	task automatic runAddSubRandom();
		logic [63:0] r;
		logic [63:0] a;
		logic [63:0] b;
		int expA;
		int expB;
		for (int i = 0; i < randomAddSubTests; i++)
		begin
			nextRandom(r);
			randomExponent(expA);
			randomExponent(expB);
			// odd tests keep the exponents close
			if (i % 2 == 1)
			begin
				expB = expA + int'(r[2:0]) - 4;
				expB = (expB < 0) ? 0 : expB;
				expB = (expB >= expLimit) ? (expLimit - 1) : expB;
			end
			randomOperand(expA, a);
			randomOperand(expB, b);
			runRequest(r[8] ? opSub : opAdd, a, b, 0);
		end
		// equal magnitudes cancel
		for (int i = 0; i < cancelTests / 2; i++)
		begin
			randomExponent(expA);
			randomOperand(expA, a);
			runRequest(opSub, a, a, 0);
			runRequest(opAdd, a, {~a[63], a[62:0]}, 0);
		end
	endtask

	task automatic runAlignment();
		logic [63:0] a;
		logic [63:0] b;
		randomOperand(1500, a);
		randomOperand(1400, b);
		runRequest(opAdd, a, b, 0);
		runRequest(opSub, a, b, 0);
		// rm larger, so subtract returns rm negated
		randomOperand(300, a);
		randomOperand(900, b);
		runRequest(opSub, a, b, 0);
		randomOperand(1000, a);
		randomOperand(1000 - maxAlignShift - 1, b);
		runRequest(opAdd, a, b, 0);
		for (int d = 1; d <= maxAlignShift; d++)
		begin
			randomOperand(1000, a);
			randomOperand(1000 - d, b);
			runRequest((d % 2 == 1) ? opSub : opAdd, a, b, 0);
		end
	endtask

	task automatic runConvert();
		logic [63:0] r;
		logic [63:0] a;
		runRequest(opI2F, 64'd0, 64'd0, 0);
		runRequest(opI2F, 64'd1, 64'd0, 0);
		runRequest(opI2F, {64{1'b1}}, 64'd0, 0);
		runRequest(opI2F, 64'h8000_0000_0000_0000, 64'd0, 0);
		for (int i = 0; i < randomConvertTests; i++)
		begin
			nextRandom(r);
			// vary the magnitude, then the sign
			a = r >> r[5:0];
			a = r[6] ? (~a + 64'd1) : a;
			runRequest(opI2F, a, r, 0);
		end
	endtask

	task automatic runZeroCases();
		logic [63:0] a;
		logic [63:0] b;
		randomOperand(1200, a);
		randomOperand(1100, b);
		runRequest(opNone, a, b, 0);
		// differences far below the smallest normal exponent
		runRequest(opSub, {1'b0, 11'd1, 52'd1}, {1'b0, 11'd1, 52'd0}, 0);
		runRequest(opAdd, {1'b0, 11'd2, 52'd3}, {1'b1, 11'd2, 52'd2}, 0);
	endtask

	task automatic runBackToBack();
		logic [63:0] r;
		logic [63:0] a;
		logic [63:0] b;
		int expA;
		int expB;
		for (int i = 0; i < backToBackTests; i++)
		begin
			nextRandom(r);
			randomExponent(expA);
			randomExponent(expB);
			randomOperand(expA, a);
			randomOperand(expB, b);
			if (fpuOp'(r[1:0]) == opI2F)
			begin
				nextRandom(a);
			end
			runRequest(fpuOp'(r[1:0]), a, b, int'(r[10:8]));
		end
	endtask

	initial
	begin
		rstN = 1'b0;
		req = 1'b0;
		op = opNone;
		rn = 64'd0;
		rm = 64'd0;
		expected = 64'd0;
		tbErrors = 0;
		rngState = 64'd82848;
		repeat (resetCycles) @(negedge clock);
		rstN = 1'b1;
		repeat (2) @(negedge clock);
		// 1.0 + 2.0
		runRequest(opAdd, 64'h3FF0_0000_0000_0000, 64'h4000_0000_0000_0000, 0);
		runAddSubRandom();
		runAlignment();
		runConvert();
		runZeroCases();
		runBackToBack();
		if ((reqCount != numTests) || (ackCount != numTests))
		begin
			$display("%0d requests and %0d acks seen, %0d requests were sent",
				reqCount, ackCount, numTests);
			tbErrors++;
		end
		totalErrors = errorCount + tbErrors;
		$display("%0d requests, %0d acks, %0d errors", reqCount, ackCount, totalErrors);
		if (totalErrors == 0)
		begin
			$display("TESTS PASSED");
		end
		else
		begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// watchdog
	initial
	begin
		repeat (numTests * cyclesPerTest + resetCycles) @(posedge clock);
		$display("Timeout: the handshakes did not finish within %0d cycles",
			numTests * cyclesPerTest + resetCycles);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== fpuAddChecker.sv ====
// FPU add handshake monitor
// captures each request, checks ack timing and result stability, and
// compares every result against the expected value given with the request
`timescale 1ns/100ps
`default_nettype none

module fpuAddChecker
	import fpuAddPkg::*;
(
	input  wire          clock,
	input  wire          rstN,
	input  wire          req,
	input  wire fpuOp    op,
	input  wire [63:0]   rn,
	input  wire [63:0]   rm,
	input  wire [63:0]   expected,
	input  wire          ack,
	input  wire [63:0]   result,
	output int           errorCount,
	output int           reqCount,
	output int           ackCount
);

	// samples between the edge that accepts a request and the one that sees ack
	localparam int ackLatency = 4;

	logic prevReq;
	logic prevAck;
	logic pending;
	logic seenReq;
	int waitCycles;
	fpuOp heldOp;
	logic [63:0] heldRn;
	logic [63:0] heldRm;
	logic [63:0] heldExpected;
	logic [63:0] heldResult;

	initial
	begin
		errorCount = 0;
		reqCount = 0;
		ackCount = 0;
		prevReq = 1'b0;
		prevAck = 1'b0;
		pending = 1'b0;
		seenReq = 1'b0;
		waitCycles = 0;
	end

	always @(posedge clock)
	begin
		if (!rstN)
		begin
			if (ack === 1'b1)
			begin
				$display("Error at %0t: ack is high during reset", $time);
				errorCount++;
			end
			prevReq = 1'b0;
			prevAck = 1'b0;
			pending = 1'b0;
		end
		else
		begin
			// idle after reset
			if (!seenReq && (result !== 64'd0))
			begin
				$display("Error at %0t: result expected %h got %h", $time, 64'd0, result);
				errorCount++;
			end
			if (pending)
			begin
				waitCycles++;
			end
			if (req && !prevReq)
			begin
				heldOp = op;
				heldRn = rn;
				heldRm = rm;
				heldExpected = expected;
				pending = 1'b1;
				seenReq = 1'b1;
				waitCycles = 0;
				reqCount++;
			end
			if (ack && !prevAck)
			begin
				heldResult = result;
				if (!pending)
				begin
					$display("Error at %0t: ack raised without a request", $time);
					errorCount++;
				end
				else
				begin
					ackCount++;
					pending = 1'b0;
					if (waitCycles != ackLatency)
					begin
						$display("Error at %0t: ack came %0d cycles after the request, not %0d",
							$time, waitCycles, ackLatency);
						errorCount++;
					end
					if (result !== heldExpected)
					begin
						$display("Error at %0t: result expected %h got %h (%s rn %h rm %h)",
							$time, heldExpected, result, heldOp.name(), heldRn, heldRm);
						errorCount++;
					end
				end
			end
			else if (ack && prevAck)
			begin
				if (result !== heldResult)
				begin
					$display("Error at %0t: result changed while ack was high", $time);
					errorCount++;
				end
				if (!prevReq)
				begin
					$display("Error at %0t: ack stayed high after req was dropped", $time);
					errorCount++;
				end
			end
			if (!ack && prevAck && prevReq)
			begin
				$display("Error at %0t: ack dropped while req was still high", $time);
				errorCount++;
			end
			prevReq = req;
			prevAck = ack;
		end
	end

endmodule

`default_nettype wire

// ==== fpuAddUnit.sv ====
// FPU add unit top level
// decode, execute and result stages behind a four-phase req/ack handshake
`timescale 1ns/100ps
`default_nettype none

module fpuAddUnit
	import fpuAddPkg::*;
(
	input  wire          clock,
	input  wire          rstN,
	input  wire          req,
	input  wire fpuOp    op,
	input  wire [63:0]   rn,
	input  wire [63:0]   rm,
	output logic         ack,
	output logic [63:0]  result
);

	// decode to execute
	logic stageValid;
	fpuOp opcode;
	logic bigSign;
	logic smallSign;
	logic [expWidth-1:0] bigExp;
	logic [mantWidth-1:0] bigMant;
	logic [mantWidth-1:0] smallMant;
	logic [63:0] intValue;

	// execute to result
	logic sumValid;
	logic sumSign;
	logic [expWidth-1:0] sumExp;
	logic [mantWidth-1:0] sumMant;

	fpuAddDecode decode0
	(
		.clock      (clock),
		.rstN       (rstN),
		.req        (req),
		.ack        (ack),
		.op         (op),
		.rn         (rn),
		.rm         (rm),
		.stageValid (stageValid),
		.opcode     (opcode),
		.bigSign    (bigSign),
		.smallSign  (smallSign),
		.bigExp     (bigExp),
		.bigMant    (bigMant),
		.smallMant  (smallMant),
		.intValue   (intValue)
	);

	fpuAddExecute execute0
	(
		.clock      (clock),
		.rstN       (rstN),
		.stageValid (stageValid),
		.opcode     (opcode),
		.bigSign    (bigSign),
		.smallSign  (smallSign),
		.bigExp     (bigExp),
		.bigMant    (bigMant),
		.smallMant  (smallMant),
		.intValue   (intValue),
		.sumValid   (sumValid),
		.sumSign    (sumSign),
		.sumExp     (sumExp),
		.sumMant    (sumMant)
	);

	fpuAddResult result0
	(
		.clock      (clock),
		.rstN       (rstN),
		.req        (req),
		.sumValid   (sumValid),
		.sumSign    (sumSign),
		.sumExp     (sumExp),
		.sumMant    (sumMant),
		.ack        (ack),
		.result     (result)
	);

endmodule

`default_nettype wire

// ==== fpuAddResult.sv ====
// FPU add result stage
// two-cycle normalize, truncate and pack, with underflow flushed to
// positive zero; owns the ack side of the handshake
`timescale 1ns/100ps
`default_nettype none

module fpuAddResult
	import fpuAddPkg::*;
(
	input  wire                    clock,
	input  wire                    rstN,
	input  wire                    req,
	input  wire                    sumValid,
	input  wire                    sumSign,
	input  wire [expWidth-1:0]     sumExp,
	input  wire [mantWidth-1:0]    sumMant,
	output logic                   ack,
	output logic [63:0]            result
);

	hsState state;

	// coarse normalize
	logic [mantWidth-1:0] shiftedMant;
	logic [2:0] byteShift;
	logic leadFound;
	logic coarseSign;
	logic [expWidth:0] coarseExp;
	logic [mantWidth-1:0] coarseMant;

	logic normValid;
	logic normSign;
	logic [expWidth:0] normExp;
	logic [mantWidth-1:0] normMant;

	// fine normalize and pack
	logic [3:0] bitShift;
	logic [expWidth:0] fineExp;
	logic [mantWidth-1:0] fineMant;
	logic [63:0] packedValue;

	always_comb
	begin
		byteShift = '0;
		leadFound = 1'b0;
		shiftedMant = '0;
		// smallest byte shift that puts a one in bits 62:54
		for (int k = 7; k >= 0; k--)
		begin
			shiftedMant = sumMant << (8 * k);
			if (shiftedMant[62:54] != '0)
			begin
				byteShift = 3'(k);
				leadFound = 1'b1;
			end
		end
		coarseSign = sumSign;
		if (sumMant[63])
		begin
			coarseExp = {1'b0, sumExp} + 1'b1;
			coarseMant = sumMant >> 1;
		end
		else if (leadFound)
		begin
			coarseExp = {1'b0, sumExp} - (expWidth + 1)'({byteShift, 3'b000});
			coarseMant = sumMant << {byteShift, 3'b000};
		end
		else
		begin
			coarseSign = 1'b0;
			coarseExp = '0;
			coarseMant = '0;
		end
	end

	always_comb
	begin
		// highest set bit in 62:55 wins, none left means a shift of 8
		bitShift = 4'd8;
		for (int i = 0; i < 8; i++)
		begin
			if (normMant[55 + i])
			begin
				bitShift = 4'(7 - i);
			end
		end
		fineMant = normMant << bitShift;
		fineExp = normExp - (expWidth + 1)'(bitShift);
		if (fineExp[expWidth])
		begin
			packedValue = '0;
		end
		else
		begin
			packedValue = {normSign, fineExp[expWidth-1:0], fineMant[guardBits +: fracWidth]};
		end
	end

	always_ff @(posedge clock)
	begin
		if (sumValid)
		begin
			normSign <= coarseSign;
			normExp <= coarseExp;
			normMant <= coarseMant;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			state <= hsIdle;
			ack <= 1'b0;
			result <= '0;
			normValid <= 1'b0;
		end
		else
		begin
			normValid <= sumValid;
			case (state)
				hsIdle:
				begin
					if (normValid)
					begin
						result <= packedValue;
						ack <= 1'b1;
						state <= hsDone;
					end
				end
				hsDone:
				begin
					// result holds until the requester lets go
					if (!req)
					begin
						ack <= 1'b0;
						state <= hsIdle;
					end
				end
				default:
				begin
					ack <= 1'b0;
					state <= hsIdle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== fpuAddExecute.sv ====
// FPU add execute stage
// adds or subtracts the aligned mantissas, or stages a signed integer
// for conversion to double
`timescale 1ns/100ps
`default_nettype none

module fpuAddExecute
	import fpuAddPkg::*;
(
	input  wire                    clock,
	input  wire                    rstN,
	input  wire                    stageValid,
	input  wire fpuOp              opcode,
	input  wire                    bigSign,
	input  wire                    smallSign,
	input  wire [expWidth-1:0]     bigExp,
	input  wire [mantWidth-1:0]    bigMant,
	input  wire [mantWidth-1:0]    smallMant,
	input  wire [63:0]             intValue,
	output logic                   sumValid,
	output logic                   sumSign,
	output logic [expWidth-1:0]    sumExp,
	output logic [mantWidth-1:0]   sumMant
);

	logic intNeg;
	logic nextSign;
	logic [expWidth-1:0] nextExp;
	logic [mantWidth-1:0] nextMant;

	assign intNeg = intValue[63];

	always_comb
	begin
		case (opcode)
			opAdd, opSub:
			begin
				nextSign = bigSign;
				nextExp = bigExp;
				// bigger magnitude first, so the difference never goes negative
				if (bigSign == smallSign)
				begin
					nextMant = bigMant + smallMant;
				end
				else
				begin
					nextMant = bigMant - smallMant;
				end
			end
			opI2F:
			begin
				nextSign = intNeg;
				nextExp = expWidth'(i2fExponent);
				nextMant = intNeg ? -intValue : intValue;
			end
			default:
			begin
				nextSign = 1'b0;
				nextExp = '0;
				nextMant = '0;
			end
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			sumValid <= 1'b0;
		end
		else
		begin
			sumValid <= stageValid;
		end
	end

	always_ff @(posedge clock)
	begin
		if (stageValid)
		begin
			sumSign <= nextSign;
			sumExp <= nextExp;
			sumMant <= nextMant;
		end
	end

endmodule

`default_nettype wire

// ==== fpuAddDecode.sv ====
// FPU add decode stage
// accepts one request per handshake, unpacks both operands, orders
// them by magnitude and right-aligns the smaller mantissa
`timescale 1ns/100ps
`default_nettype none

module fpuAddDecode
	import fpuAddPkg::*;
(
	input  wire                    clock,
	input  wire                    rstN,
	input  wire                    req,
	input  wire                    ack,
	input  wire fpuOp              op,
	input  wire [63:0]             rn,
	input  wire [63:0]             rm,
	output logic                   stageValid,
	output fpuOp                   opcode,
	output logic                   bigSign,
	output logic                   smallSign,
	output logic [expWidth-1:0]    bigExp,
	output logic [mantWidth-1:0]   bigMant,
	output logic [mantWidth-1:0]   smallMant,
	output logic [63:0]            intValue
);

	hsState state;
	logic accept;

	logic rnSign;
	logic rmSign;
	logic [expWidth-1:0] rnExp;
	logic [expWidth-1:0] rmExp;
	logic [mantWidth-1:0] rnMant;
	logic [mantWidth-1:0] rmMant;
	logic rnIsBig;
	logic [expWidth-1:0] alignShift;
	logic [mantWidth-1:0] smallRaw;
	logic [mantWidth-1:0] alignedMant;

	assign accept = (state == hsIdle) && req;

	// unpack, hidden bit only for a non-zero exponent
	assign rnSign = rn[63];
	assign rmSign = rm[63] ^ (op == opSub);
	assign rnExp = rn[fracWidth +: expWidth];
	assign rmExp = rm[fracWidth +: expWidth];
	assign rnMant = {1'b0, rnExp != '0, rn[fracWidth-1:0], {guardBits{1'b0}}};
	assign rmMant = {1'b0, rmExp != '0, rm[fracWidth-1:0], {guardBits{1'b0}}};

	// order by exponent, then by mantissa
	assign rnIsBig = (rnExp > rmExp) || ((rnExp == rmExp) && (rnMant >= rmMant));
	assign alignShift = rnIsBig ? (rnExp - rmExp) : (rmExp - rnExp);
	assign smallRaw = rnIsBig ? rmMant : rnMant;
	assign alignedMant = (alignShift > expWidth'(maxAlignShift)) ? '0 : (smallRaw >> alignShift);

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			state <= hsIdle;
			stageValid <= 1'b0;
		end
		else
		begin
			stageValid <= accept;
			case (state)
				hsIdle:
				begin
					if (req)
					begin
						state <= hsBusy;
					end
				end
				hsBusy:
				begin
					// requester released req after ack; result drops ack on this edge
					if (!req && ack)
					begin
						state <= hsIdle;
					end
				end
				default:
				begin
					state <= hsIdle;
				end
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			opcode <= op;
			intValue <= rn;
			smallMant <= alignedMant;
			if (rnIsBig)
			begin
				bigSign <= rnSign;
				smallSign <= rmSign;
				bigExp <= rnExp;
				bigMant <= rnMant;
			end
			else
			begin
				bigSign <= rmSign;
				smallSign <= rnSign;
				bigExp <= rmExp;
				bigMant <= rmMant;
			end
		end
	end

endmodule

`default_nettype wire

// ==== fpuAddPkg.sv ====
// FPU add package
// opcode and handshake encodings, and the double-precision format
// constants shared by the add unit
`default_nettype none

package fpuAddPkg;

	// requested operation
	typedef enum logic [1:0]
	{
		opNone = 2'd0,
		opAdd  = 2'd1,
		opSub  = 2'd2,
		opI2F  = 2'd3
	} fpuOp;

	// four-phase handshake tracking
	typedef enum logic [1:0]
	{
		hsIdle = 2'd0,
		hsBusy = 2'd1,
		hsDone = 2'd2
	} hsState;

	localparam int expWidth = 11;
	localparam int fracWidth = 52;

	// overflow bit, hidden bit, 52 fraction bits, guard bits
	localparam int mantWidth = 64;
	localparam int guardBits = 10;

	// beyond this difference the smaller operand shifts out entirely
	localparam int maxAlignShift = 52;

	// biased exponent of 2^62, the weight of the hidden bit position
	localparam int i2fExponent = 1085;

endpackage

`default_nettype wire
